// ==== source/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

// BR with nzp zero, never taken
localparam lc3b_word nop_word = 16'h0000;

// Instruction fields
localparam int op_hi = 15;
localparam int op_lo = 12;
localparam int dr_hi = 11;
localparam int dr_lo = 9;
localparam int sr1_hi = 8;
localparam int sr1_lo = 6;
localparam int sr2_hi = 2;
localparam int sr2_lo = 0;
localparam int imm_bit = 5;

endpackage : lc3b_types

// ==== source/lc3b_pipe.sv ====
package lc3b_pipe;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

// All zero is a bubble
typedef struct packed {
	lc3b_types::lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic imm_sel;
	logic sext_sel;
	logic mem_read;
	logic mem_write;
	logic byte_op;
	logic load_regfile;
	logic load_cc;
	logic is_branch;
} lc3b_control_word;

typedef struct packed {
	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_reg dest;
	lc3b_types::lc3b_reg sr1;
	lc3b_types::lc3b_reg sr2;
	lc3b_types::lc3b_nzp nzp;
	logic [8:0] offset9;
	lc3b_types::lc3b_word immediate;
} lc3b_passed_vals;

typedef struct packed {
	lc3b_types::lc3b_word address;
	lc3b_types::lc3b_word wdata;
	logic read;
	logic write;
	logic [1:0] byte_enable;
} mem_req_t;

typedef struct packed {
	logic resp;
	lc3b_types::lc3b_word rdata;
} mem_rsp_t;

localparam lc3b_types::lc3b_word reset_pc = 16'h0000;

endpackage : lc3b_pipe

// ==== source/control_rom.sv ====
`timescale 1ns/1ns

module control_rom (
	input lc3b_types::lc3b_word instr,
	output lc3b_pipe::lc3b_control_word ctrl
);

lc3b_types::lc3b_opcode opcode;

assign opcode = lc3b_types::lc3b_opcode'(instr[lc3b_types::op_hi:lc3b_types::op_lo]);

always_comb begin
	ctrl = '0;
	case (opcode)
		lc3b_types::op_add, lc3b_types::op_and: begin
			ctrl.opcode = opcode;
			ctrl.aluop = (opcode == lc3b_types::op_add) ? lc3b_pipe::alu_add : lc3b_pipe::alu_and;
			ctrl.imm_sel = instr[lc3b_types::imm_bit];
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_not: begin
			ctrl.opcode = opcode;
			ctrl.aluop = lc3b_pipe::alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_ldr, lc3b_types::op_ldb: begin
			ctrl.opcode = opcode;
			ctrl.aluop = lc3b_pipe::alu_add;
			ctrl.imm_sel = 1'b1;
			ctrl.sext_sel = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.byte_op = (opcode == lc3b_types::op_ldb);
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_str, lc3b_types::op_stb: begin
			ctrl.opcode = opcode;
			ctrl.aluop = lc3b_pipe::alu_add;
			ctrl.imm_sel = 1'b1;
			ctrl.sext_sel = 1'b1;
			ctrl.mem_write = 1'b1;
			ctrl.byte_op = (opcode == lc3b_types::op_stb);
		end
		lc3b_types::op_br: begin
			// nzp of zero stays a bubble
			if (instr[lc3b_types::dr_hi:lc3b_types::dr_lo] != 3'b000) begin
				ctrl.opcode = opcode;
				ctrl.aluop = lc3b_pipe::alu_pass;
				ctrl.is_branch = 1'b1;
			end
		end
		default: begin
		end
	endcase
end

endmodule : control_rom

// ==== source/regfile.sv ====
`timescale 1ns/1ns

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

lc3b_types::lc3b_word data [8];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++) begin
			data[i] <= '0;
		end
	end else if (load) begin
		data[dest] <= in;
	end
end

// Write-through on a same-cycle read
assign reg_a = (load && dest == src_a) ? in : data[src_a];
assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu (
	input lc3b_pipe::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);

always_comb begin
	case (aluop)
		lc3b_pipe::alu_add: begin
			f = a + b;
		end
		lc3b_pipe::alu_and: begin
			f = a & b;
		end
		lc3b_pipe::alu_not: begin
			f = ~a;
		end
		lc3b_pipe::alu_pass: begin
			f = b;
		end
		default: begin
			f = b;
		end
	endcase
end

endmodule : alu

// ==== source/data_forwarding.sv ====
`timescale 1ns/1ns

module data_forwarding (
	input lc3b_types::lc3b_word sr1_data,
	input lc3b_types::lc3b_word sr2_data,
	input lc3b_types::lc3b_reg sr1_addr,
	input lc3b_types::lc3b_reg sr2_addr,
	input logic ex_write,
	input lc3b_types::lc3b_reg ex_dest,
	input lc3b_types::lc3b_word ex_data,
	input logic wb_write,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	output lc3b_types::lc3b_word sr1_out,
	output lc3b_types::lc3b_word sr2_out
);

// Youngest producer wins
function automatic lc3b_types::lc3b_word pick(input lc3b_types::lc3b_reg addr,
		input lc3b_types::lc3b_word rf_data);
	if (ex_write && ex_dest == addr)
		return ex_data;
	if (wb_write && wb_dest == addr)
		return wb_data;
	return rf_data;
endfunction

always_comb begin
	sr1_out = pick(sr1_addr, sr1_data);
	sr2_out = pick(sr2_addr, sr2_data);
end

endmodule : data_forwarding

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input lc3b_types::lc3b_word redirect_pc,
	output lc3b_pipe::mem_req_t imem_req,
	input lc3b_pipe::mem_rsp_t imem_rsp,
	output lc3b_types::lc3b_word instr,
	output lc3b_types::lc3b_word instr_pc,
	output logic ready
);

lc3b_types::lc3b_word pc;
lc3b_types::lc3b_word held;
logic have;
logic run;

assign imem_req.address = pc;
assign imem_req.wdata = '0;
assign imem_req.read = run & ~have;
assign imem_req.write = 1'b0;
assign imem_req.byte_enable = 2'b11;

assign ready = have | imem_rsp.resp;
// Fetched word is dropped on a redirect
assign instr = redirect ? lc3b_types::nop_word : (have ? held : imem_rsp.rdata);
assign instr_pc = pc;

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= lc3b_pipe::reset_pc;
		have <= 1'b0;
		run <= 1'b0;
	end else begin
		run <= 1'b1;
		if (!stall) begin
			pc <= redirect ? redirect_pc : pc + 16'd2;
			have <= 1'b0;
		end else if (imem_rsp.resp) begin
			have <= 1'b1;
		end
	end
end

// Keep the word while the rest of the pipe waits
always_ff @(posedge clk) begin
	if (imem_rsp.resp) begin
		held <= imem_rsp.rdata;
	end
end

endmodule : fetch_unit

// ==== source/data_port.sv ====
`timescale 1ns/1ns

module data_port (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_pipe::lc3b_control_word ctrl,
	input lc3b_types::lc3b_word address,
	input lc3b_types::lc3b_word wdata,
	output lc3b_pipe::mem_req_t dmem_req,
	input lc3b_pipe::mem_rsp_t dmem_rsp,
	output lc3b_types::lc3b_word rdata,
	output logic ready
);

lc3b_types::lc3b_word held;
logic done;
logic access;

assign access = ctrl.mem_read | ctrl.mem_write;

assign dmem_req.address = address;
assign dmem_req.wdata = ctrl.byte_op ? {2{wdata[7:0]}} : wdata;
assign dmem_req.read = ctrl.mem_read & ~done;
assign dmem_req.write = ctrl.mem_write & ~done;
assign dmem_req.byte_enable = ctrl.byte_op ? (address[0] ? 2'b10 : 2'b01) : 2'b11;

assign ready = ~access | done | dmem_rsp.resp;
assign rdata = done ? held : dmem_rsp.rdata;

// One access per instruction, done until the pipe moves
always_ff @(posedge clk) begin
	if (reset) begin
		done <= 1'b0;
	end else if (!stall) begin
		done <= 1'b0;
	end else if (dmem_rsp.resp) begin
		done <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (dmem_rsp.resp) begin
		held <= dmem_rsp.rdata;
	end
end

endmodule : data_port

// ==== source/datapath.sv ====
`timescale 1ns/1ns

module datapath (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word instr_pc,
	input logic fetch_ready,
	input logic data_ready,
	output logic stall,
	output logic redirect,
	output lc3b_types::lc3b_word redirect_pc,
	output lc3b_pipe::lc3b_control_word ex_ctrl,
	output lc3b_types::lc3b_word ex_address,
	output lc3b_types::lc3b_word ex_wdata,
	input lc3b_types::lc3b_word load_data
);

lc3b_types::lc3b_word ir, ir_pc;
lc3b_pipe::lc3b_control_word gen_ctrl, id_ctrl, mem_ctrl;
lc3b_pipe::lc3b_passed_vals gen_vals, id_vals, ex_vals, mem_vals;
lc3b_types::lc3b_word id_sr1_data, id_sr2_data;
lc3b_types::lc3b_word mem_alu, mem_rdata;
lc3b_types::lc3b_word reg_a, reg_b, fwd_sr1, fwd_sr2, alu_b, alu_out;
lc3b_types::lc3b_word imm5, offset6, wb_value, branch_target;
lc3b_types::lc3b_nzp cc_reg, cc_now;
logic interlock, taken;

function automatic lc3b_types::lc3b_nzp gen_cc(input lc3b_types::lc3b_word value);
	if (value[15])
		return 3'b100;
	if (value == 16'h0000)
		return 3'b010;
	return 3'b001;
endfunction

assign stall = ~(fetch_ready & data_ready);

// Decode
control_rom i_control_rom (
	.instr(ir),
	.ctrl(gen_ctrl)
);

assign imm5 = {{11{ir[4]}}, ir[4:0]};
// Word offsets are scaled by two
assign offset6 = gen_ctrl.byte_op ? {{10{ir[5]}}, ir[5:0]} : {{9{ir[5]}}, ir[5:0], 1'b0};

always_comb begin
	gen_vals.pc = ir_pc + 16'd2;
	gen_vals.dest = ir[lc3b_types::dr_hi:lc3b_types::dr_lo];
	gen_vals.sr1 = ir[lc3b_types::sr1_hi:lc3b_types::sr1_lo];
	gen_vals.sr2 = gen_ctrl.mem_write ? ir[lc3b_types::dr_hi:lc3b_types::dr_lo]
		: ir[lc3b_types::sr2_hi:lc3b_types::sr2_lo];
	gen_vals.nzp = ir[lc3b_types::dr_hi:lc3b_types::dr_lo];
	gen_vals.offset9 = ir[8:0];
	gen_vals.immediate = gen_ctrl.sext_sel ? offset6 : imm5;
end

regfile i_regfile (
	.clk,
	.reset,
	.load(mem_ctrl.load_regfile & ~stall),
	.dest(mem_vals.dest),
	.in(wb_value),
	.src_a(gen_vals.sr1),
	.src_b(gen_vals.sr2),
	.reg_a,
	.reg_b
);

// Load result or branch CC not ready in time, one bubble
assign interlock = ~taken && ((id_ctrl.mem_read && (gen_ctrl.load_regfile || gen_ctrl.mem_write)
	&& (id_vals.dest == gen_vals.sr1 || id_vals.dest == gen_vals.sr2))
	|| (gen_ctrl.is_branch && id_ctrl.load_cc));

// Execute
data_forwarding i_data_forwarding (
	.sr1_data(id_sr1_data),
	.sr2_data(id_sr2_data),
	.sr1_addr(id_vals.sr1),
	.sr2_addr(id_vals.sr2),
	.ex_write(ex_ctrl.load_regfile),
	.ex_dest(ex_vals.dest),
	.ex_data(ex_address),
	.wb_write(mem_ctrl.load_regfile),
	.wb_dest(mem_vals.dest),
	.wb_data(wb_value),
	.sr1_out(fwd_sr1),
	.sr2_out(fwd_sr2)
);

assign alu_b = id_ctrl.imm_sel ? id_vals.immediate : fwd_sr2;

alu i_alu (
	.aluop(id_ctrl.aluop),
	.a(fwd_sr1),
	.b(alu_b),
	.f(alu_out)
);

assign cc_now = mem_ctrl.load_cc ? gen_cc(wb_value) : cc_reg;
assign branch_target = id_vals.pc + {{6{id_vals.offset9[8]}}, id_vals.offset9, 1'b0};
assign taken = id_ctrl.is_branch && ((id_vals.nzp & cc_now) != 3'b000);
// On an interlock the fetch restarts at the instruction behind ID
assign redirect = taken | interlock;
assign redirect_pc = taken ? branch_target : gen_vals.pc;

// Writeback
always_comb begin
	if (!mem_ctrl.mem_read)
		wb_value = mem_alu;
	else if (!mem_ctrl.byte_op)
		wb_value = mem_rdata;
	else if (mem_alu[0])
		wb_value = {8'h00, mem_rdata[15:8]};
	else
		wb_value = {8'h00, mem_rdata[7:0]};
end

always_ff @(posedge clk) begin
	if (reset) begin
		ir <= lc3b_types::nop_word;
		id_ctrl <= '0;
		ex_ctrl <= '0;
		mem_ctrl <= '0;
		cc_reg <= 3'b010;
	end else if (!stall) begin
		if (!interlock)
			ir <= instr;
		id_ctrl <= redirect ? '0 : gen_ctrl;
		ex_ctrl <= id_ctrl;
		mem_ctrl <= ex_ctrl;
		if (mem_ctrl.load_cc)
			cc_reg <= cc_now;
	end
end

always_ff @(posedge clk) begin
	if (!stall) begin
		if (!interlock)
			ir_pc <= instr_pc;
		id_vals <= gen_vals;
		id_sr1_data <= reg_a;
		id_sr2_data <= reg_b;
		ex_vals <= id_vals;
		ex_address <= alu_out;
		ex_wdata <= fwd_sr2;
		mem_vals <= ex_vals;
		mem_alu <= ex_address;
		mem_rdata <= load_data;
	end
end

endmodule : datapath

// ==== source/lc3b_cpu.sv ====
`timescale 1ns/1ns

module lc3b_cpu (
	input logic clk,
	input logic reset,
	output lc3b_pipe::mem_req_t imem_req,
	input lc3b_pipe::mem_rsp_t imem_rsp,
	output lc3b_pipe::mem_req_t dmem_req,
	input lc3b_pipe::mem_rsp_t dmem_rsp
);

lc3b_types::lc3b_word instr, instr_pc, redirect_pc;
lc3b_types::lc3b_word ex_address, ex_wdata, load_data;
lc3b_pipe::lc3b_control_word ex_ctrl;
logic fetch_ready, data_ready, stall, redirect;

fetch_unit i_fetch_unit (
	.clk,
	.reset,
	.stall,
	.redirect,
	.redirect_pc,
	.imem_req,
	.imem_rsp,
	.instr,
	.instr_pc,
	.ready(fetch_ready)
);

datapath i_datapath (
	.clk,
	.reset,
	.instr,
	.instr_pc,
	.fetch_ready,
	.data_ready,
	.stall,
	.redirect,
	.redirect_pc,
	.ex_ctrl,
	.ex_address,
	.ex_wdata,
	.load_data
);

data_port i_data_port (
	.clk,
	.reset,
	.stall,
	.ctrl(ex_ctrl),
	.address(ex_address),
	.wdata(ex_wdata),
	.dmem_req,
	.dmem_rsp,
	.rdata(load_data),
	.ready(data_ready)
);

endmodule : lc3b_cpu

// ==== bench/lc3b_cpu_properties.sv ====
`timescale 1ns/1ns

module lc3b_cpu_properties (
	input logic clk,
	input logic reset,
	input lc3b_pipe::mem_req_t imem_req,
	input lc3b_pipe::mem_rsp_t imem_rsp,
	input lc3b_pipe::mem_req_t dmem_req,
	input lc3b_pipe::mem_rsp_t dmem_rsp
);

int error_count = 0;

imem_stable: assert property (@(posedge clk) disable iff (reset)
	(imem_req.read || imem_req.write) && !imem_rsp.resp |=> $stable(imem_req))
	else begin
		$error("imem request changed before resp");
		error_count++;
	end

dmem_stable: assert property (@(posedge clk) disable iff (reset)
	(dmem_req.read || dmem_req.write) && !dmem_rsp.resp |=> $stable(dmem_req))
	else begin
		$error("dmem request changed before resp");
		error_count++;
	end

one_direction: assert property (@(posedge clk) disable iff (reset)
	!(dmem_req.read && dmem_req.write))
	else begin
		$error("read and write raised together");
		error_count++;
	end

// First reset cycle skipped while registers settle
quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |->
	!(imem_req.read || imem_req.write || dmem_req.read || dmem_req.write))
	else begin
		$error("memory request raised during reset");
		error_count++;
	end

endmodule : lc3b_cpu_properties

bind lc3b_cpu lc3b_cpu_properties i_lc3b_cpu_properties (.*);

// ==== bench/lc3b_cpu_tb.sv ====
`timescale 1ns/1ns

module lc3b_cpu_tb;

localparam int rand_len = 40;
localparam lc3b_types::lc3b_word end_pc = 16'd96;

logic clk = 1'b0;
logic reset = 1'b1;
lc3b_pipe::mem_req_t imem_req;
lc3b_pipe::mem_req_t dmem_req;
lc3b_pipe::mem_rsp_t imem_rsp = '0;
lc3b_pipe::mem_rsp_t dmem_rsp = '0;

logic [31:0] lfsr = 32'h7621;
lc3b_types::lc3b_word prog [64];
logic [7:0] dmem [65536];
logic [7:0] model_mem [65536];
lc3b_pipe::mem_req_t exp_stores [$];
int store_count = 0;
int exp_count = 0;
int imem_wait = 0;
int dmem_wait = 0;
logic imem_busy = 1'b0;
logic dmem_busy = 1'b0;
lc3b_types::lc3b_word daddr;

lc3b_cpu i_lc3b_cpu (
	.clk,
	.reset,
	.imem_req,
	.imem_rsp,
	.dmem_req,
	.dmem_rsp
);

always #2 clk = ~clk;

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	logic fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		v = {v[14:0], fb};
	end
	return v;
endfunction

task automatic stop_with_error(input string msg);
	$display("%s", msg);
	$display("TESTBENCH FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input lc3b_types::lc3b_word got,
		input lc3b_types::lc3b_word exp);
	if (got !== exp)
		stop_with_error($sformatf("Fail %s got %h expected %h", name, got, exp));
endtask

task automatic check_store(input lc3b_pipe::mem_req_t got, input lc3b_pipe::mem_req_t exp);
	if (got !== exp)
		stop_with_error($sformatf("Fail dmem_req got %h expected %h", got, exp));
endtask

function automatic lc3b_types::lc3b_nzp nzp_of(input lc3b_types::lc3b_word v);
	if (v[15])
		return 3'b100;
	else if (v == 16'h0000)
		return 3'b010;
	else
		return 3'b001;
endfunction

function automatic lc3b_types::lc3b_word random_instr(input int idx);
	logic [2:0] kind, dr, sr1, sr2;
	logic [5:0] imm6;
	logic flag;
	logic [8:0] off;
	kind = rand_bits(3);
	dr = rand_bits(3);
	sr1 = rand_bits(3);
	sr2 = rand_bits(3);
	imm6 = rand_bits(6);
	flag = rand_bits(1);
	off = rand_bits(2);
	case (kind)
		3'd0: return {4'b0001, dr, sr1, 3'b000, sr2};
		3'd1: return {4'b0001, dr, sr1, 1'b1, imm6[4:0]};
		3'd2: return flag ? {4'b0101, dr, sr1, 1'b1, imm6[4:0]} : {4'b0101, dr, sr1, 3'b000, sr2};
		3'd3: return {4'b1001, dr, sr1, 6'b111111};
		3'd4: return {4'b0110, dr, sr1, imm6};
		3'd5: return {4'b0010, dr, sr1, imm6};
		3'd6: return {flag ? 4'b0011 : 4'b0111, dr, sr1, imm6};
		default: begin
			// Branch target must stay inside the random part
			if (int'(off) > rand_len - 1 - idx)
				off = 9'(rand_len - 1 - idx);
			return {4'b0000, sr1, off};
		end
	endcase
endfunction

task automatic build_program();
	for (int i = 0; i < 64; i++)
		prog[i] = lc3b_types::nop_word;
	for (int i = 0; i < rand_len; i++)
		prog[i] = random_instr(i);
	// Register dump as STR Ri, R0, #i
	for (int i = 0; i < 8; i++)
		prog[rand_len + i] = {4'b0111, 3'(i), 3'b000, 6'(i)};
	prog[rand_len + 8] = 16'h0FFF;
endtask

// ISA-level interpreter
task automatic run_model();
	lc3b_types::lc3b_word r [8];
	lc3b_types::lc3b_word pc, ir, addr, v;
	lc3b_types::lc3b_nzp cc;
	lc3b_pipe::mem_req_t req;
	int steps;
	for (int i = 0; i < 8; i++)
		r[i] = '0;
	cc = 3'b010;
	pc = lc3b_pipe::reset_pc;
	steps = 0;
	while (pc != end_pc && steps < 500) begin
		ir = prog[pc[6:1]];
		pc = pc + 16'd2;
		steps++;
		case (ir[15:12])
			4'b0001, 4'b0101: begin
				v = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
				v = (ir[15:12] == 4'b0001) ? r[ir[8:6]] + v : r[ir[8:6]] & v;
				r[ir[11:9]] = v;
				cc = nzp_of(v);
			end
			4'b1001: begin
				r[ir[11:9]] = ~r[ir[8:6]];
				cc = nzp_of(~r[ir[8:6]]);
			end
			4'b0110: begin
				addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
				v = {model_mem[addr | 16'd1], model_mem[addr & ~16'd1]};
				r[ir[11:9]] = v;
				cc = nzp_of(v);
			end
			4'b0010: begin
				addr = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
				v = {8'h00, model_mem[addr]};
				r[ir[11:9]] = v;
				cc = nzp_of(v);
			end
			4'b0111: begin
				addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
				v = r[ir[11:9]];
				model_mem[addr & ~16'd1] = v[7:0];
				model_mem[addr | 16'd1] = v[15:8];
				req = '{address: addr, wdata: v, read: 1'b0, write: 1'b1, byte_enable: 2'b11};
				exp_stores.push_back(req);
			end
			4'b0011: begin
				addr = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
				v = r[ir[11:9]];
				model_mem[addr] = v[7:0];
				req = '{address: addr, wdata: {2{v[7:0]}}, read: 1'b0, write: 1'b1,
					byte_enable: addr[0] ? 2'b10 : 2'b01};
				exp_stores.push_back(req);
			end
			4'b0000: begin
				if ((ir[11:9] & cc) != 3'b000)
					pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
			end
			default: begin
			end
		endcase
	end
	if (pc != end_pc)
		stop_with_error("Reference model did not reach the end of the program");
endtask

task automatic record_store(input lc3b_pipe::mem_req_t req);
	if (exp_stores.size() == 0) begin
		stop_with_error("The DUT wrote data memory more often than the reference model");
	end else begin
		check_store(req, exp_stores.pop_front());
		if (req.byte_enable[0])
			dmem[req.address & ~16'd1] = req.wdata[7:0];
		if (req.byte_enable[1])
			dmem[req.address | 16'd1] = req.wdata[15:8];
		store_count++;
	end
endtask

// Both memories with 0 to 3 wait cycles each
always @(negedge clk) begin
	if (reset) begin
		imem_rsp = '0;
		dmem_rsp = '0;
		imem_busy = 1'b0;
		dmem_busy = 1'b0;
	end else begin
		imem_rsp = '0;
		if (imem_req.read) begin
			if (!imem_busy) begin
				imem_busy = 1'b1;
				imem_wait = rand_bits(2);
			end
			if (imem_wait == 0) begin
				imem_busy = 1'b0;
				imem_rsp.resp = 1'b1;
				imem_rsp.rdata = (imem_req.address < 16'd128) ? prog[imem_req.address[6:1]]
					: lc3b_types::nop_word;
			end else begin
				imem_wait--;
			end
		end
		dmem_rsp = '0;
		if (dmem_req.read || dmem_req.write) begin
			if (!dmem_busy) begin
				dmem_busy = 1'b1;
				dmem_wait = rand_bits(2);
			end
			if (dmem_wait == 0) begin
				dmem_busy = 1'b0;
				dmem_rsp.resp = 1'b1;
				daddr = dmem_req.address;
				dmem_rsp.rdata = {dmem[daddr | 16'd1], dmem[daddr & ~16'd1]};
				if (dmem_req.write)
					record_store(dmem_req);
			end else begin
				dmem_wait--;
			end
		end
	end
end

always @(negedge clk) begin
	if (i_lc3b_cpu.i_lc3b_cpu_properties.error_count != 0)
		stop_with_error("An assertion on the memory handshake or reset failed");
end

initial begin
	int cycles;
	for (int a = 0; a < 65536; a++) begin
		dmem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3c;
		model_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3c;
	end
	build_program();
	run_model();
	exp_count = exp_stores.size();
	repeat (8) @(negedge clk);
	reset = 1'b0;

	cycles = 0;
	while (!imem_req.read && cycles < 20) begin
		@(negedge clk);
		cycles++;
	end
	if (!imem_req.read) begin
		stop_with_error("No instruction fetch started after reset");
	end else begin
		check_word("imem_req.address", imem_req.address, lc3b_pipe::reset_pc);
		check_word("dmem_req.read_write", {14'h0, dmem_req.read, dmem_req.write}, 16'h0);
	end

	cycles = 0;
	while (store_count < exp_count && cycles < 20000) begin
		@(negedge clk);
		cycles++;
	end
	if (store_count < exp_count)
		stop_with_error("Timed out waiting for the expected data-memory stores");

	// Idle in the final loop where any further store is an error
	repeat (100) @(negedge clk);
	if (i_lc3b_cpu.i_lc3b_cpu_properties.error_count != 0) begin
		stop_with_error("An assertion on the memory handshake or reset failed");
	end else begin
		$display("TESTBENCH PASSED");
		$finish;
	end
end

endmodule : lc3b_cpu_tb

// ==== list.f ====
source/lc3b_types.sv
source/lc3b_pipe.sv
source/control_rom.sv
source/regfile.sv
source/alu.sv
source/data_forwarding.sv
source/fetch_unit.sv
source/data_port.sv
source/datapath.sv
source/lc3b_cpu.sv
bench/lc3b_cpu_properties.sv
bench/lc3b_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_cpu

sources:
  - files:
      - source/lc3b_types.sv
      - source/lc3b_pipe.sv
      - source/control_rom.sv
      - source/regfile.sv
      - source/alu.sv
      - source/data_forwarding.sv
      - source/fetch_unit.sv
      - source/data_port.sv
      - source/datapath.sv
      - source/lc3b_cpu.sv
  - target: simulation
    files:
      - bench/lc3b_cpu_properties.sv
      - bench/lc3b_cpu_tb.sv
